// ==== hw/decode_pkg.sv ====
// Decode stage shared definitions
// Widths, x86 opcode and prefix codes, field types and the
// instruction and micro-op structs passed between the pipe stages

package decode_pkg;

   localparam int ADDR_W = 32;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [15:0]       opcode_t;
   typedef logic [23:0]       prefix_t;
   typedef logic [1:0]        count_t;
   typedef logic [2:0]        size_t;
   typedef logic [2:0]        operand_sel_t;
   typedef logic [3:0]        alu_op_t;
   typedef logic [2:0]        seg_t;
   typedef logic [31:0]       imm_t;

   // First opcode byte
   localparam logic [7:0] OP_PUSH_ES      = 8'h06;
   localparam logic [7:0] OP_PUSH_CS      = 8'h0E;
   localparam logic [7:0] OP_PUSH_SS      = 8'h16;
   localparam logic [7:0] OP_PUSH_DS      = 8'h1E;
   localparam logic [7:0] OP_SHIFT1_B     = 8'hD0;
   localparam logic [7:0] OP_SHIFT1_W     = 8'hD1;
   localparam logic [7:0] OP_MOVS         = 8'hA5;
   localparam logic [7:0] OP_RET_NEAR     = 8'hC3;
   localparam logic [7:0] OP_RET_NEAR_IMM = 8'hC2;
   localparam logic [7:0] OP_RET_FAR      = 8'hCB;
   localparam logic [7:0] OP_RET_FAR_IMM  = 8'hCA;

   // Two byte opcodes
   localparam opcode_t OP_PUSH_FS = 16'h0FA0;
   localparam opcode_t OP_PUSH_GS = 16'h0FA8;

   localparam logic [7:0] PFX_ES     = 8'h26;
   localparam logic [7:0] PFX_CS     = 8'h2E;
   localparam logic [7:0] PFX_SS     = 8'h36;
   localparam logic [7:0] PFX_DS     = 8'h3E;
   localparam logic [7:0] PFX_FS     = 8'h64;
   localparam logic [7:0] PFX_GS     = 8'h65;
   localparam logic [7:0] PFX_REP    = 8'hF3;
   localparam logic [7:0] PFX_REPNE  = 8'hF2;
   localparam logic [7:0] PFX_OPSIZE = 8'h66;

   localparam seg_t SEG_ES = 3'd0;
   localparam seg_t SEG_CS = 3'd1;
   localparam seg_t SEG_SS = 3'd2;
   localparam seg_t SEG_DS = 3'd3;
   localparam seg_t SEG_FS = 3'd4;
   localparam seg_t SEG_GS = 3'd5;

   localparam size_t        SIZE_16      = 3'd2;
   localparam size_t        SIZE_32      = 3'd3;
   localparam operand_sel_t OPND_STRING  = 3'd6;
   localparam alu_op_t      ALU_PASS     = 4'd0;
   localparam alu_op_t      ALU_MOVE_STR = 4'd4;

   typedef struct packed {
      prefix_t    prefix;
      count_t     prefix_bytes;
      opcode_t    opcode;
      count_t     opcode_bytes;
      logic [7:0] modrm;
      imm_t       imm;
      addr_t      pc;
      logic       size_override;
   } instr_t;

   typedef struct packed {
      size_t        size;
      operand_sel_t op0;
      operand_sel_t op1;
      alu_op_t      alu_op;
      logic [7:0]   modrm;
      imm_t         imm;
      seg_t         seg_override;
      logic         seg_override_valid;
      opcode_t      opcode;
      addr_t        pc;
      logic         movs;
   } uop_t;

endpackage

// ==== hw/field_decode.sv ====
`timescale 1ns/1ps
// Field decoder of the x86 decode stage
// Masks prefix and opcode bytes, decodes prefixes, applies the
// opcode overrides and flags near and far returns

module field_decode (
   input  decode_pkg::instr_t s0_instr,
   input  logic               s0_valid,
   output decode_pkg::uop_t   uop,
   output logic               rep,
   output logic               is_return,
   output logic               near_return,
   output logic               far_return
);

   decode_pkg::prefix_t mask_prefix;
   decode_pkg::opcode_t mask_op;
   logic [7:0]          op_hi;
   decode_pkg::seg_t    seg_override;
   logic                seg_valid;
   logic                opsize_prefix;
   logic                push_seg;
   logic                shift_one;
   logic                movs;
   logic                near_opc;
   logic                far_opc;

   // Valid bit and segment code of one prefix byte
   function automatic logic [3:0] seg_of(input logic [7:0] pb);
      case (pb)
         decode_pkg::PFX_ES: seg_of = {1'b1, decode_pkg::SEG_ES};
         decode_pkg::PFX_CS: seg_of = {1'b1, decode_pkg::SEG_CS};
         decode_pkg::PFX_SS: seg_of = {1'b1, decode_pkg::SEG_SS};
         decode_pkg::PFX_DS: seg_of = {1'b1, decode_pkg::SEG_DS};
         decode_pkg::PFX_FS: seg_of = {1'b1, decode_pkg::SEG_FS};
         decode_pkg::PFX_GS: seg_of = {1'b1, decode_pkg::SEG_GS};
         default:            seg_of = 4'h0;
      endcase
   endfunction

   // Uncounted bytes read as zero, which matches no prefix
   always_comb begin
      case (s0_instr.prefix_bytes)
         2'd0:    mask_prefix = '0;
         2'd1:    mask_prefix = {s0_instr.prefix[23:16], 16'h0000};
         2'd2:    mask_prefix = {s0_instr.prefix[23:8], 8'h00};
         default: mask_prefix = s0_instr.prefix;
      endcase
   end

   assign mask_op = s0_instr.opcode_bytes[1] ? s0_instr.opcode
                                             : {s0_instr.opcode[15:8], 8'h00};
   assign op_hi   = mask_op[15:8];

   // Last byte scanned first so the earliest segment prefix wins
   always_comb begin
      logic [3:0] hit;
      seg_override  = decode_pkg::SEG_ES;
      seg_valid     = 1'b0;
      rep           = 1'b0;
      opsize_prefix = 1'b0;
      for (int i = 0; i < 3; i++) begin
         hit = seg_of(mask_prefix[8*i +: 8]);
         if (hit[3]) begin
            {seg_valid, seg_override} = hit;
         end
         if (mask_prefix[8*i +: 8] == decode_pkg::PFX_REP ||
             mask_prefix[8*i +: 8] == decode_pkg::PFX_REPNE) begin
            rep = 1'b1;
         end
         if (mask_prefix[8*i +: 8] == decode_pkg::PFX_OPSIZE) begin
            opsize_prefix = 1'b1;
         end
      end
   end

   // Segment pushes are always 32 bit
   assign push_seg = op_hi == decode_pkg::OP_PUSH_ES || op_hi == decode_pkg::OP_PUSH_CS ||
                     op_hi == decode_pkg::OP_PUSH_SS || op_hi == decode_pkg::OP_PUSH_DS ||
                     mask_op == decode_pkg::OP_PUSH_FS || mask_op == decode_pkg::OP_PUSH_GS;

   assign shift_one = op_hi == decode_pkg::OP_SHIFT1_B || op_hi == decode_pkg::OP_SHIFT1_W;
   assign movs      = op_hi == decode_pkg::OP_MOVS;
   assign near_opc  = op_hi == decode_pkg::OP_RET_NEAR || op_hi == decode_pkg::OP_RET_NEAR_IMM;
   assign far_opc   = op_hi == decode_pkg::OP_RET_FAR || op_hi == decode_pkg::OP_RET_FAR_IMM;

   assign is_return   = near_opc | far_opc;
   assign near_return = near_opc & s0_valid;
   assign far_return  = far_opc & s0_valid;

   always_comb begin
      if (push_seg || !(s0_instr.size_override || opsize_prefix)) begin
         uop.size = decode_pkg::SIZE_32;
      end else begin
         uop.size = decode_pkg::SIZE_16;
      end
      uop.op0                = movs ? decode_pkg::OPND_STRING : s0_instr.modrm[5:3];
      uop.op1                = movs ? decode_pkg::OPND_STRING : s0_instr.modrm[2:0];
      uop.alu_op             = movs ? decode_pkg::ALU_MOVE_STR : decode_pkg::ALU_PASS;
      uop.modrm              = s0_instr.modrm;
      uop.imm                = shift_one ? decode_pkg::imm_t'(1) : s0_instr.imm;
      uop.seg_override       = seg_override;
      uop.seg_override_valid = seg_valid;
      uop.opcode             = mask_op;
      // Filled in by the issue selector
      uop.pc                 = '0;
      uop.movs               = movs;
   end

endmodule

// ==== hw/repeat_control.sv ====
`timescale 1ns/1ps
// Repeat controller for REP string instructions
// Posts ECX-1 on every issued iteration and stalls issue for one
// cycle after each writeback so the next count is never stale

module repeat_control (
   input  logic              ret_near,
   input  logic              ret_far,
   input  logic              rep,
   input  logic              accept_out,
   input  decode_pkg::addr_t ecx,
   output logic              last_iter,
   output logic              hold_issue,
   output logic              wb_valid,
   output decode_pkg::addr_t wb_data
);

   logic ecx_is_one;
   logic wb_in_flight;

   assign ecx_is_one = ecx == decode_pkg::addr_t'(1);

   // Non-REP instructions always retire on the first issue
   assign last_iter = !rep || ecx_is_one;

   assign wb_valid = accept_out & rep;
   assign wb_data  = ecx - decode_pkg::addr_t'(1);

   // ECX written back this cycle, visible at the input next-next cycle
   always_ff @(posedge ret_near or posedge ret_far) begin
      if (ret_far) begin
         wb_in_flight <= 1'b0;
      end else begin
         wb_in_flight <= wb_valid;
      end
   end

   assign hold_issue = wb_in_flight;

   // Issue gating downstream must keep iterations apart
   a_no_wb_in_hold: assert property (
      @(posedge ret_near) disable iff (ret_far)
      hold_issue |-> !wb_valid
   );

   // A REP count of zero is not supported
   a_rep_ecx_nonzero: assert property (
      @(posedge ret_near) disable iff (ret_far)
      (rep && accept_out) |-> (ecx != '0)
   );

endmodule

// ==== hw/issue_select.sv ====
`timescale 1ns/1ps
// Issue selector of the decode stage
// Gates the valid/ready handshake, keeps the current EIP register
// and picks the PC that goes out with the micro-op

module issue_select (
   input  logic              ret_near,
   input  logic              ret_far,
   input  logic              s0_valid,
   output logic              s0_ready,
   output logic              s1_valid,
   input  logic              s1_ready,
   input  decode_pkg::uop_t  uop_in,
   input  decode_pkg::addr_t pc,
   input  logic              is_return,
   input  logic              near_return,
   input  logic              far_return,
   input  logic              last_iter,
   input  logic              hold_issue,
   output logic              accept_out,
   input  logic              write_eip,
   input  decode_pkg::addr_t eip,
   output decode_pkg::addr_t curr_eip,
   output decode_pkg::uop_t  s1_uop
);

   logic eip_load;

   // Nothing issues while a count writeback is in flight
   assign s1_valid = s0_valid & ~hold_issue;

   // REP keeps the instruction at the input until the last iteration
   assign s0_ready = s1_ready & ~hold_issue & last_iter;

   assign accept_out = s1_valid & s1_ready;

   // A return takes EIP priority over an external write
   assign eip_load = write_eip & ~(near_return | far_return);

   always_ff @(posedge ret_near or posedge ret_far) begin
      if (ret_far) begin
         curr_eip <= '0;
      end else if (eip_load) begin
         curr_eip <= eip;
      end
   end

   always_comb begin
      s1_uop = uop_in;
      if (is_return) begin
         s1_uop.pc = curr_eip;
      end else begin
         s1_uop.pc = pc;
      end
   end

   a_valid_from_input: assert property (
      @(posedge ret_near) disable iff (ret_far)
      s1_valid |-> s0_valid
   );

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
// x86 decode stage top
// Field decoder and REP controller run side by side, the issue
// selector joins them into one micro-op per output transfer

module decode_stage (
   input  logic               ret_near,
   input  logic               ret_far,
   input  logic               s0_valid,
   output logic               s0_ready,
   input  decode_pkg::instr_t s0_instr,
   output logic               s1_valid,
   input  logic               s1_ready,
   output decode_pkg::uop_t   s1_uop,
   input  decode_pkg::addr_t  ecx,
   output logic               wb_valid,
   output decode_pkg::addr_t  wb_data,
   input  logic               write_eip,
   input  decode_pkg::addr_t  eip,
   output decode_pkg::addr_t  curr_eip,
   output logic               near_return,
   output logic               far_return
);

   decode_pkg::uop_t dec_uop;
   logic             rep;
   logic             is_return;
   logic             last_iter;
   logic             hold_issue;
   logic             accept_out;

   field_decode field_decode_inst (
      .s0_instr    (s0_instr),
      .s0_valid    (s0_valid),
      .uop         (dec_uop),
      .rep         (rep),
      .is_return   (is_return),
      .near_return (near_return),
      .far_return  (far_return)
   );

   repeat_control repeat_control_inst (
      .ret_near   (ret_near),
      .ret_far    (ret_far),
      .rep        (rep),
      .accept_out (accept_out),
      .ecx        (ecx),
      .last_iter  (last_iter),
      .hold_issue (hold_issue),
      .wb_valid   (wb_valid),
      .wb_data    (wb_data)
   );

   issue_select issue_select_inst (
      .ret_near    (ret_near),
      .ret_far     (ret_far),
      .s0_valid    (s0_valid),
      .s0_ready    (s0_ready),
      .s1_valid    (s1_valid),
      .s1_ready    (s1_ready),
      .uop_in      (dec_uop),
      .pc          (s0_instr.pc),
      .is_return   (is_return),
      .near_return (near_return),
      .far_return  (far_return),
      .last_iter   (last_iter),
      .hold_issue  (hold_issue),
      .accept_out  (accept_out),
      .write_eip   (write_eip),
      .eip         (eip),
      .curr_eip    (curr_eip),
      .s1_uop      (s1_uop)
   );

endmodule

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/1ps
// Testbench for the x86 decode stage
// Random instructions, back-pressure, REP MOVS countdown, returns and EIP updates

module decode_stage_tb;

   localparam int WAIT_LIMIT = 200;

   logic ret_near;
   logic ret_far;
   logic s0_valid;
   logic s0_ready;
   logic s1_valid;
   logic s1_ready;
   logic wb_valid;
   logic write_eip;
   logic near_return;
   logic far_return;
   decode_pkg::instr_t s0_instr;
   decode_pkg::uop_t   s1_uop;
   decode_pkg::addr_t  ecx;
   decode_pkg::addr_t  wb_data;
   decode_pkg::addr_t  eip;
   decode_pkg::addr_t  curr_eip;

   decode_pkg::addr_t ecx_model = '0;
   decode_pkg::addr_t eip_model = '0;
   logic [31:0]       lcg_state = 32'h636b;
   int                out_count = 0;
   int                cycle_no = 0;
   int                last_rep_cycle = -10;
   logic              exp_near;
   logic              exp_far;

   decode_stage decode_stage_inst (.*);

   initial begin
      ret_near = 1'b0;
      forever #10 ret_near = ~ret_near;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic fail_run();
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_uop(input decode_pkg::uop_t got, input decode_pkg::uop_t exp);
      if (got !== exp) begin
         $display("Error: s1_uop got %h expected %h", got, exp);
         fail_run();
      end
   endtask

   task automatic check_addr(input string name, input decode_pkg::addr_t got,
                             input decode_pkg::addr_t exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         fail_run();
      end
   endtask

   function automatic int seg_code(input logic [7:0] pb);
      case (pb)
         decode_pkg::PFX_ES: return 0;
         decode_pkg::PFX_CS: return 1;
         decode_pkg::PFX_SS: return 2;
         decode_pkg::PFX_DS: return 3;
         decode_pkg::PFX_FS: return 4;
         decode_pkg::PFX_GS: return 5;
         default:            return -1;
      endcase
   endfunction

   function automatic logic has_rep(input decode_pkg::instr_t in);
      logic [7:0] pb;
      has_rep = 1'b0;
      for (int i = 0; i < int'(in.prefix_bytes); i++) begin
         pb = in.prefix[23-8*i -: 8];
         if (pb == decode_pkg::PFX_REP || pb == decode_pkg::PFX_REPNE) has_rep = 1'b1;
      end
   endfunction

   // Expected micro-op built byte by byte from the counted prefixes
   function automatic decode_pkg::uop_t ref_uop(input decode_pkg::instr_t in,
                                                input decode_pkg::addr_t eip_val);
      decode_pkg::uop_t u;
      logic [7:0]       pb;
      logic [7:0]       hi;
      logic             opsize;
      u = '0;
      opsize = in.size_override;
      for (int i = 0; i < int'(in.prefix_bytes); i++) begin
         pb = in.prefix[23-8*i -: 8];
         if (pb == decode_pkg::PFX_OPSIZE) opsize = 1'b1;
         if (!u.seg_override_valid && seg_code(pb) >= 0) begin
            u.seg_override_valid = 1'b1;
            u.seg_override = decode_pkg::seg_t'(seg_code(pb));
         end
      end
      u.opcode = in.opcode_bytes[1] ? in.opcode : {in.opcode[15:8], 8'h00};
      hi = u.opcode[15:8];
      u.modrm = in.modrm;
      u.size = opsize ? decode_pkg::SIZE_16 : decode_pkg::SIZE_32;
      if (hi == decode_pkg::OP_PUSH_ES || hi == decode_pkg::OP_PUSH_CS ||
          hi == decode_pkg::OP_PUSH_SS || hi == decode_pkg::OP_PUSH_DS ||
          u.opcode == decode_pkg::OP_PUSH_FS || u.opcode == decode_pkg::OP_PUSH_GS)
         u.size = decode_pkg::SIZE_32;
      u.imm = (hi == decode_pkg::OP_SHIFT1_B || hi == decode_pkg::OP_SHIFT1_W) ? 32'd1 : in.imm;
      u.movs = hi == decode_pkg::OP_MOVS;
      u.op0 = u.movs ? decode_pkg::OPND_STRING : in.modrm[5:3];
      u.op1 = u.movs ? decode_pkg::OPND_STRING : in.modrm[2:0];
      u.alu_op = u.movs ? decode_pkg::ALU_MOVE_STR : decode_pkg::ALU_PASS;
      u.pc = (hi == decode_pkg::OP_RET_NEAR || hi == decode_pkg::OP_RET_NEAR_IMM ||
              hi == decode_pkg::OP_RET_FAR || hi == decode_pkg::OP_RET_FAR_IMM) ? eip_val : in.pc;
      return u;
   endfunction

   // Never picks a REP byte
   function automatic logic [7:0] pick_prefix(input logic [31:0] r);
      case (r[31:29])
         3'd0:    return decode_pkg::PFX_ES;
         3'd1:    return decode_pkg::PFX_CS;
         3'd2:    return decode_pkg::PFX_SS;
         3'd3:    return decode_pkg::PFX_DS;
         3'd4:    return decode_pkg::PFX_FS;
         3'd5:    return decode_pkg::PFX_GS;
         3'd6:    return decode_pkg::PFX_OPSIZE;
         default: return {1'b0, r[22:16]};
      endcase
   endfunction

   function automatic decode_pkg::opcode_t pick_opcode(input logic [31:0] r);
      case (r[31:28])
         4'd0:    return {decode_pkg::OP_PUSH_ES, r[7:0]};
         4'd1:    return {decode_pkg::OP_PUSH_CS, r[7:0]};
         4'd2:    return {decode_pkg::OP_PUSH_SS, r[7:0]};
         4'd3:    return {decode_pkg::OP_PUSH_DS, r[7:0]};
         4'd4:    return {decode_pkg::OP_SHIFT1_B, r[7:0]};
         4'd5:    return {decode_pkg::OP_SHIFT1_W, r[7:0]};
         4'd6:    return {decode_pkg::OP_MOVS, r[7:0]};
         4'd7:    return {decode_pkg::OP_RET_NEAR, r[7:0]};
         4'd8:    return {decode_pkg::OP_RET_NEAR_IMM, r[7:0]};
         4'd9:    return {decode_pkg::OP_RET_FAR, r[7:0]};
         4'd10:   return {decode_pkg::OP_RET_FAR_IMM, r[7:0]};
         4'd11:   return decode_pkg::OP_PUSH_FS;
         4'd12:   return decode_pkg::OP_PUSH_GS;
         default: return r[15:0];
      endcase
   endfunction

   // Uncounted prefix slots sometimes carry a REP byte that must be ignored
   function automatic decode_pkg::instr_t rand_instr();
      decode_pkg::instr_t in;
      logic [31:0]        r;
      in.prefix_bytes = decode_pkg::count_t'(lcg_next() >> 30);
      for (int i = 0; i < 3; i++) begin
         r = lcg_next();
         if (i < int'(in.prefix_bytes) || !r[0]) in.prefix[23-8*i -: 8] = pick_prefix(r);
         else in.prefix[23-8*i -: 8] = decode_pkg::PFX_REP;
      end
      in.opcode = pick_opcode(lcg_next());
      in.opcode_bytes = decode_pkg::count_t'(lcg_next() >> 30);
      in.modrm = 8'(lcg_next() >> 24);
      in.imm = lcg_next();
      in.pc = lcg_next();
      in.size_override = 1'(lcg_next() >> 31);
      return in;
   endfunction

   task automatic drive_side();
      logic [31:0] r;
      r = lcg_next();
      s1_ready = r[31:30] != 2'b00;
      write_eip = r[29:27] == 3'b000;
      eip = lcg_next();
      ecx = ecx_model;
   endtask

   // Called on a falling edge, returns on the falling edge after the input transfer
   task automatic send_instr(input decode_pkg::instr_t in, input int n_out);
      int   cycles;
      logic taken;
      cycles = 0;
      taken = 1'b0;
      s0_valid = 1'b1;
      s0_instr = in;
      out_count = 0;
      drive_side();
      while (!taken) begin
         @(posedge ret_near);
         taken = s0_valid && s0_ready;
         @(negedge ret_near);
         cycles++;
         if (!taken && cycles > WAIT_LIMIT) begin
            $display("Timeout: instruction was never accepted at the input");
            fail_run();
         end
         drive_side();
      end
      if (out_count != n_out) begin
         $display("Instruction made %0d output transfers instead of %0d", out_count, n_out);
         fail_run();
      end
   endtask

   always @(posedge ret_near) begin
      if (!ret_far) begin
         exp_near = s0_valid && (s0_instr.opcode[15:8] == decode_pkg::OP_RET_NEAR ||
                                 s0_instr.opcode[15:8] == decode_pkg::OP_RET_NEAR_IMM);
         exp_far = s0_valid && (s0_instr.opcode[15:8] == decode_pkg::OP_RET_FAR ||
                                s0_instr.opcode[15:8] == decode_pkg::OP_RET_FAR_IMM);
         check_bit("near_return", near_return, exp_near);
         check_bit("far_return", far_return, exp_far);
         check_addr("curr_eip", curr_eip, eip_model);
         if (s0_ready && !s1_ready) begin
            $display("Input was ready while the output was stalled");
            fail_run();
         end
         if (s1_valid && s1_ready) begin
            check_uop(s1_uop, ref_uop(s0_instr, eip_model));
            out_count++;
            check_bit("wb_valid", wb_valid, has_rep(s0_instr));
            if (has_rep(s0_instr)) begin
               check_addr("wb_data", wb_data, ecx_model - 1);
               if (last_rep_cycle == cycle_no - 1) begin
                  $display("Two REP iterations issued on adjacent cycles");
                  fail_run();
               end
               last_rep_cycle = cycle_no;
            end
         end else begin
            check_bit("wb_valid", wb_valid, 1'b0);
         end
         if (write_eip && !(exp_near || exp_far)) eip_model <= eip;
         if (wb_valid) ecx_model <= wb_data;
         cycle_no++;
      end
   end

   initial begin
      decode_pkg::instr_t in;
      int                 n;
      s0_valid = 1'b0;
      s0_instr = '0;
      s1_ready = 1'b0;
      ecx = '0;
      write_eip = 1'b0;
      eip = '0;
      ret_far = 1'b1;
      repeat (4) @(negedge ret_near);
      ret_far = 1'b0;
      check_addr("curr_eip", curr_eip, '0);
      for (int i = 0; i < 300; i++) begin
         in = rand_instr();
         send_instr(in, 1);
      end
      for (int k = 0; k < 20; k++) begin
         n = int'(lcg_next() >> 16) % 6 + 1;
         ecx_model = n;
         in = rand_instr();
         in.prefix_bytes = decode_pkg::count_t'(int'(lcg_next() >> 16) % 3 + 1);
         in.prefix[23:16] = decode_pkg::PFX_REP;
         in.opcode = {decode_pkg::OP_MOVS, 8'h00};
         in.opcode_bytes = 2'd1;
         send_instr(in, n);
         check_addr("ecx", ecx_model, '0);
      end
      s0_valid = 1'b0;
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== sim.f ====
hw/decode_pkg.sv
hw/field_decode.sv
hw/repeat_control.sv
hw/issue_select.sv
hw/decode_stage.sv
bench/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - hw/decode_pkg.sv
      - hw/field_decode.sv
      - hw/repeat_control.sv
      - hw/issue_select.sv
      - hw/decode_stage.sv
  - target: simulation
    files:
      - bench/decode_stage_tb.sv
